// File: src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam int DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
    localparam logic [31:0] HALT_ADDRESS = 32'h00000000;
    localparam int V0_INDEX = 2;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALT      = 3'd5
    } stateT;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcodeT;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOpT;

endpackage

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  mipsPkg::aluOpT                  aluOp,
    input  logic [mipsPkg::DATA_WIDTH-1:0]  operandA,
    input  logic [mipsPkg::DATA_WIDTH-1:0]  operandB,
    input  logic [4:0]                      shamt,
    output logic [mipsPkg::DATA_WIDTH-1:0]  result,
    output logic                            zero
);

    import mipsPkg::*;

    logic signedLess;
    logic unsignedLess;

    assign signedLess = $signed(operandA) < $signed(operandB);
    assign unsignedLess = operandA < operandB;

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = operandA + operandB;
            ALU_SUB:  result = operandA - operandB;
            ALU_AND:  result = operandA & operandB;
            ALU_OR:   result = operandA | operandB;
            ALU_XOR:  result = operandA ^ operandB;
            ALU_SLT:  result = {{(DATA_WIDTH-1){1'b0}}, signedLess};
            ALU_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, unsignedLess};
            // Shifts act on the rt operand
            ALU_SLL:  result = operandB << shamt;
            ALU_SRL:  result = operandB >> shamt;
            ALU_SRA:  result = $signed(operandB) >>> shamt;
            ALU_LUI:  result = {operandB[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // Equality for BEQ and BNE
    assign zero = (operandA == operandB);

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mipsPkg::REG_ADDR_WIDTH-1:0]  rsIndex,
    input  logic [mipsPkg::REG_ADDR_WIDTH-1:0]  rtIndex,
    input  logic [mipsPkg::REG_ADDR_WIDTH-1:0]  writeIndex,
    input  logic [mipsPkg::DATA_WIDTH-1:0]      writeData,
    input  logic                                writeEnable,
    output logic [mipsPkg::DATA_WIDTH-1:0]      rsData,
    output logic [mipsPkg::DATA_WIDTH-1:0]      rtData,
    output logic [mipsPkg::DATA_WIDTH-1:0]      v0Data
);

    import mipsPkg::*;

    logic [DATA_WIDTH-1:0] regs [0:(1 << REG_ADDR_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << REG_ADDR_WIDTH); i++)
                regs[i] <= '0;
        end else if (writeEnable && (writeIndex != '0)) begin
            // Register 0 stays hardwired to zero
            regs[writeIndex] <= writeData;
        end
    end

    assign rsData = regs[rsIndex];
    assign rtData = regs[rtIndex];
    assign v0Data = regs[V0_INDEX];

endmodule

`default_nettype wire

// File: src/pcUnit.sv
`timescale 1ns/1ns
`default_nettype none

module pcUnit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            pcAdvance,
    input  logic                            branchTaken,
    input  logic [mipsPkg::DATA_WIDTH-1:0]  branchTarget,
    output logic [mipsPkg::DATA_WIDTH-1:0]  pc,
    output logic                            halted
);

    import mipsPkg::*;

    logic                  pendingValid;
    logic [DATA_WIDTH-1:0] pendingTarget;

    // A taken branch is held one instruction so the delay slot runs first
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_VECTOR;
            pendingValid <= 1'b0;
        end else if (pcAdvance) begin
            if (pendingValid)
                pc <= pendingTarget;
            else
                pc <= pc + 32'd4;
            pendingValid <= branchTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (pcAdvance && branchTaken)
            pendingTarget <= branchTarget;
    end

    assign halted = (pc == HALT_ADDRESS);

endmodule

`default_nettype wire

// File: src/controlFsm.sv
`timescale 1ns/1ns
`default_nettype none

module controlFsm (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                waitrequest,
    input  logic [mipsPkg::DATA_WIDTH-1:0]      readdata,
    input  logic [mipsPkg::DATA_WIDTH-1:0]      pc,
    input  logic                                halted,
    input  logic [mipsPkg::DATA_WIDTH-1:0]      rsData,
    input  logic [mipsPkg::DATA_WIDTH-1:0]      rtData,
    input  logic [mipsPkg::DATA_WIDTH-1:0]      aluResult,
    input  logic                                aluZero,
    output logic [mipsPkg::DATA_WIDTH-1:0]      address,
    output logic                                read,
    output logic                                write,
    output logic [mipsPkg::DATA_WIDTH-1:0]      writedata,
    output logic [3:0]                          byteenable,
    output logic                                active,
    output logic [mipsPkg::REG_ADDR_WIDTH-1:0]  rsIndex,
    output logic [mipsPkg::REG_ADDR_WIDTH-1:0]  rtIndex,
    output logic [mipsPkg::REG_ADDR_WIDTH-1:0]  writeIndex,
    output logic [mipsPkg::DATA_WIDTH-1:0]      writeData,
    output logic                                writeEnable,
    output mipsPkg::aluOpT                      aluOp,
    output logic [mipsPkg::DATA_WIDTH-1:0]      aluImmediate,
    output logic                                useImmediate,
    output logic [4:0]                          shamt,
    output logic                                pcAdvance,
    output logic                                branchTaken,
    output logic [mipsPkg::DATA_WIDTH-1:0]      branchTarget
);

    import mipsPkg::*;

    stateT                 state;
    logic [DATA_WIDTH-1:0] instr;
    logic [DATA_WIDTH-1:0] aluOut;
    logic [DATA_WIDTH-1:0] loadData;
    opcodeT                opcode;
    functT                 funct;
    logic [15:0]           imm;
    logic [DATA_WIDTH-1:0] pcPlus4;
    logic zeroExtend, writesRd, writesRt, isLoad, isStore;
    logic isBeq, isBne, isJump, isJr;

    // Bus words are little-endian, so every word crosses byte-reversed
    function automatic logic [31:0] byteSwap(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    assign opcode  = opcodeT'(instr[31:26]);
    assign funct   = functT'(instr[5:0]);
    assign imm     = instr[15:0];
    assign rsIndex = instr[25:21];
    assign rtIndex = instr[20:16];
    assign shamt   = instr[10:6];
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        aluOp = ALU_ADD;
        useImmediate = 1'b1;
        zeroExtend = 1'b0;
        {writesRd, writesRt, isLoad, isStore} = 4'b0000;
        {isBeq, isBne, isJump, isJr} = 4'b0000;
        case (opcode)
            OP_SPECIAL: begin
                useImmediate = 1'b0;
                writesRd = 1'b1;
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_JR: begin
                        writesRd = 1'b0;
                        isJr = 1'b1;
                    end
                    // Unknown function completes as a no-op
                    default: writesRd = 1'b0;
                endcase
            end
            OP_ADDIU: writesRt = 1'b1;
            OP_SLTI: begin
                aluOp = ALU_SLT;
                writesRt = 1'b1;
            end
            OP_SLTIU: begin
                aluOp = ALU_SLTU;
                writesRt = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                aluOp = (opcode == OP_ANDI) ? ALU_AND :
                        (opcode == OP_ORI)  ? ALU_OR  :
                        (opcode == OP_XORI) ? ALU_XOR : ALU_LUI;
                zeroExtend = 1'b1;
                writesRt = 1'b1;
            end
            OP_LW: isLoad = 1'b1;
            OP_SW: isStore = 1'b1;
            OP_BEQ, OP_BNE: begin
                aluOp = ALU_SUB;
                useImmediate = 1'b0;
                isBeq = (opcode == OP_BEQ);
                isBne = (opcode == OP_BNE);
            end
            OP_J: isJump = 1'b1;
            default: ;
        endcase
    end

    assign aluImmediate = zeroExtend ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    // Branch target and decision, applied by pcUnit after the delay slot
    assign branchTarget = isJump ? {pcPlus4[31:28], instr[25:0], 2'b00} :
                          isJr   ? rsData :
                                   pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign branchTaken = (state == EXECUTE) &&
                         (isJump || isJr || (isBeq && aluZero) || (isBne && !aluZero));

    assign pcAdvance = ((state == EXECUTE) && !(isLoad || isStore || writesRd || writesRt)) ||
                       ((state == MEMORY) && !waitrequest && isStore) ||
                       (state == WRITEBACK);

    // Bus side
    assign read = ((state == FETCH) && !halted) || ((state == MEMORY) && isLoad);
    assign write = (state == MEMORY) && isStore;
    assign address = (state == MEMORY) ? {aluOut[31:2], 2'b00} : pc;
    assign writedata = byteSwap(rtData);
    assign byteenable = 4'b1111;

    // Register writeback
    assign writeIndex = writesRd ? instr[15:11] : instr[20:16];
    assign writeData = isLoad ? loadData : aluOut;
    assign writeEnable = (state == WRITEBACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            active <= 1'b1;
        end else begin
            case (state)
                FETCH: begin
                    if (halted) begin
                        state <= HALT;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    if (isLoad || isStore)
                        state <= MEMORY;
                    else if (writesRd || writesRt)
                        state <= WRITEBACK;
                    else
                        state <= FETCH;
                end
                MEMORY: begin
                    if (!waitrequest)
                        state <= isLoad ? WRITEBACK : FETCH;
                end
                WRITEBACK: state <= FETCH;
                default: state <= HALT;
            endcase
        end
    end

    // Instruction, ALU and load data registers
    always_ff @(posedge clk) begin
        if ((state == FETCH) && read && !waitrequest)
            instr <= byteSwap(readdata);
        if (state == EXECUTE)
            aluOut <= aluResult;
        if ((state == MEMORY) && !waitrequest)
            loadData <= byteSwap(readdata);
    end

endmodule

`default_nettype wire

// File: src/mipsCpuBus.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCpuBus (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            active,
    output logic [mipsPkg::DATA_WIDTH-1:0]  register_v0,

    // Avalon master
    output logic [mipsPkg::DATA_WIDTH-1:0]  address,
    output logic                            write,
    output logic                            read,
    input  logic                            waitrequest,
    output logic [mipsPkg::DATA_WIDTH-1:0]  writedata,
    output logic [3:0]                      byteenable,
    input  logic [mipsPkg::DATA_WIDTH-1:0]  readdata
);

    import mipsPkg::*;

    logic [DATA_WIDTH-1:0]     pc;
    logic                      halted;
    logic                      pcAdvance;
    logic                      branchTaken;
    logic [DATA_WIDTH-1:0]     branchTarget;

    logic [REG_ADDR_WIDTH-1:0] rsIndex;
    logic [REG_ADDR_WIDTH-1:0] rtIndex;
    logic [REG_ADDR_WIDTH-1:0] writeIndex;
    logic [DATA_WIDTH-1:0]     regWriteData;
    logic                      writeEnable;
    logic [DATA_WIDTH-1:0]     rsData;
    logic [DATA_WIDTH-1:0]     rtData;

    aluOpT                     aluOp;
    logic [DATA_WIDTH-1:0]     aluImmediate;
    logic                      useImmediate;
    logic [4:0]                shamt;
    logic [DATA_WIDTH-1:0]     aluResult;
    logic                      aluZero;

    controlFsm uControl (
        .clk          (clk),
        .reset        (reset),
        .waitrequest  (waitrequest),
        .readdata     (readdata),
        .pc           (pc),
        .halted       (halted),
        .rsData       (rsData),
        .rtData       (rtData),
        .aluResult    (aluResult),
        .aluZero      (aluZero),
        .address      (address),
        .read         (read),
        .write        (write),
        .writedata    (writedata),
        .byteenable   (byteenable),
        .active       (active),
        .rsIndex      (rsIndex),
        .rtIndex      (rtIndex),
        .writeIndex   (writeIndex),
        .writeData    (regWriteData),
        .writeEnable  (writeEnable),
        .aluOp        (aluOp),
        .aluImmediate (aluImmediate),
        .useImmediate (useImmediate),
        .shamt        (shamt),
        .pcAdvance    (pcAdvance),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    regFile uRegs (
        .clk         (clk),
        .reset       (reset),
        .rsIndex     (rsIndex),
        .rtIndex     (rtIndex),
        .writeIndex  (writeIndex),
        .writeData   (regWriteData),
        .writeEnable (writeEnable),
        .rsData      (rsData),
        .rtData      (rtData),
        .v0Data      (register_v0)
    );

    // Operand B is rt or the extended immediate
    alu uAlu (
        .aluOp    (aluOp),
        .operandA (rsData),
        .operandB (useImmediate ? aluImmediate : rtData),
        .shamt    (shamt),
        .result   (aluResult),
        .zero     (aluZero)
    );

    pcUnit uPc (
        .clk          (clk),
        .reset        (reset),
        .pcAdvance    (pcAdvance),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (pc),
        .halted       (halted)
    );

endmodule

`default_nettype wire

// File: tests/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic clk
);

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: tests/mipsCpuBus_assert.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCpuBus_assert (
    input logic        clk,
    input logic        reset,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic [31:0] address,
    input logic        active
);

    // Only one direction per transfer
    assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write high together");

    // A stalled transfer keeps its request and address
    assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitrequest) |=> ((read || write) && $stable(address)))
        else $error("address or request changed during waitrequest");

    // Halt is sticky until reset
    assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else $error("active rose without reset");

endmodule

bind mipsCpuBus mipsCpuBus_assert uBusChecks (
    .clk         (clk),
    .reset       (reset),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .active      (active)
);

`default_nettype wire

// File: tests/mipsTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsTb;

    localparam logic [31:0] BOOT_ADDRESS = 32'hBFC00000;
    // Six short programs of at most 20 instructions, 5 cycles each plus
    // up to 3 wait cycles per transfer and 8 reset cycles, with ample margin
    localparam int CYCLE_LIMIT = 2000;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] prog [$];
    integer      seed;
    int          errorCount;
    int          cycleCount;
    bit          randomWaits;
    bit          busy;
    int          waitLeft;

    tbClock uClock (.clk(clk));

    mipsCpuBus u_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (registerV0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    // Memory holds little-endian bus words
    function automatic logic [31:0] toBusWord(input logic [31:0] word);
        return {word[7:0], word[15:8], word[23:16], word[31:24]};
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Unwritten words read back as a pattern of their address
    function automatic logic [31:0] memRead(input logic [31:0] addr);
        if (mem.exists(addr))
            return mem[addr];
        return addr ^ 32'h5A5A5A5A;
    endfunction

    // Avalon slave, answered on the falling edge
    always @(negedge clk) begin
        if (read || write) begin
            if (!busy) begin
                busy = 1'b1;
                waitLeft = randomWaits ? ($unsigned($random(seed)) % 4) : 0;
            end
            if (waitLeft > 0) begin
                waitrequest = 1'b1;
                waitLeft--;
            end else begin
                waitrequest = 1'b0;
                // Every transfer is a full word
                if (byteenable !== 4'b1111) begin
                    $display("mismatch bus byteenable: expected %b, actual %b",
                             4'b1111, byteenable);
                    errorCount++;
                end
                if (read)
                    readdata = memRead(address);
                else
                    mem[address] = writedata;
                busy = 1'b0;
            end
        end else begin
            waitrequest = 1'b0;
            busy = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compareWord(input string testName, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", testName, expected, actual);
            errorCount++;
        end
    endtask

    // JR $0 with a NOP in its delay slot ends every program
    task automatic endProgram();
        prog.push_back(rType(5'd0, 5'd0, 5'd0, 5'd0, 6'd8));
        prog.push_back(32'h0);
    endtask

    task automatic runProgram(input bit withWaits);
        @(negedge clk);
        reset = 1'b1;
        randomWaits = withWaits;
        mem.delete();
        foreach (prog[i])
            mem[BOOT_ADDRESS + 4 * i] = toBusWord(prog[i]);
        repeat (8) @(negedge clk);
        reset = 1'b0;
        do @(negedge clk); while (active);
    endtask

    task automatic aluTest(input string testName, input bit withWaits);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] expected;
        a = 32'd100;
        b = 32'h12345678;
        c = -32'sd3;
        expected = ((((b + a) - c) & c) | b) ^ c;
        expected = expected + (($signed(c) < $signed(a)) ? 1 : 0) + ((c < a) ? 1 : 0);
        prog = {};
        prog.push_back(iType(6'd9, 5'd0, 5'd8, 16'd100));
        prog.push_back(iType(6'd15, 5'd0, 5'd9, 16'h1234));
        prog.push_back(iType(6'd13, 5'd9, 5'd9, 16'h5678));
        prog.push_back(iType(6'd9, 5'd0, 5'd10, 16'hFFFD));
        prog.push_back(rType(5'd9, 5'd8, 5'd11, 5'd0, 6'd33));
        prog.push_back(rType(5'd11, 5'd10, 5'd12, 5'd0, 6'd35));
        prog.push_back(rType(5'd12, 5'd10, 5'd13, 5'd0, 6'd36));
        prog.push_back(rType(5'd13, 5'd9, 5'd14, 5'd0, 6'd37));
        prog.push_back(rType(5'd14, 5'd10, 5'd15, 5'd0, 6'd38));
        prog.push_back(rType(5'd10, 5'd8, 5'd16, 5'd0, 6'd42));
        prog.push_back(rType(5'd10, 5'd8, 5'd17, 5'd0, 6'd43));
        prog.push_back(rType(5'd15, 5'd16, 5'd2, 5'd0, 6'd33));
        prog.push_back(rType(5'd2, 5'd17, 5'd2, 5'd0, 6'd33));
        endProgram();
        runProgram(withWaits);
        compareWord(testName, expected, registerV0);
    endtask

    task automatic immediateShiftTest();
        logic [31:0] x;
        logic [31:0] andi;
        logic [31:0] expected;
        x = 32'hFFFFFFF0;
        andi = x & 32'h00008F0F;
        expected = ((andi + (x ^ 32'h0000FFFF)) ^ (x >> 4)) + (andi << 8);
        expected = expected + (($signed(x) < -1) ? 1 : 0);
        expected = expected + ((x < 32'hFFFFFFFF) ? 32'd16 : 32'd0);
        expected = expected - 32'($signed(x) >>> 4);
        prog = {};
        prog.push_back(iType(6'd9, 5'd0, 5'd8, 16'hFFF0));
        prog.push_back(iType(6'd12, 5'd8, 5'd9, 16'h8F0F));
        prog.push_back(iType(6'd14, 5'd8, 5'd10, 16'hFFFF));
        prog.push_back(iType(6'd10, 5'd8, 5'd11, 16'hFFFF));
        prog.push_back(iType(6'd11, 5'd8, 5'd12, 16'hFFFF));
        prog.push_back(rType(5'd0, 5'd8, 5'd14, 5'd4, 6'd3));
        prog.push_back(rType(5'd0, 5'd8, 5'd15, 5'd4, 6'd2));
        prog.push_back(rType(5'd0, 5'd9, 5'd16, 5'd8, 6'd0));
        prog.push_back(rType(5'd9, 5'd10, 5'd2, 5'd0, 6'd33));
        prog.push_back(rType(5'd2, 5'd15, 5'd2, 5'd0, 6'd38));
        prog.push_back(rType(5'd2, 5'd16, 5'd2, 5'd0, 6'd33));
        prog.push_back(rType(5'd2, 5'd11, 5'd2, 5'd0, 6'd33));
        prog.push_back(rType(5'd0, 5'd12, 5'd12, 5'd4, 6'd0));
        prog.push_back(rType(5'd2, 5'd12, 5'd2, 5'd0, 6'd33));
        prog.push_back(rType(5'd2, 5'd14, 5'd2, 5'd0, 6'd35));
        endProgram();
        runProgram(1'b0);
        compareWord("immediates", expected, registerV0);
    endtask

    task automatic memoryTest();
        prog = {};
        prog.push_back(iType(6'd9, 5'd0, 5'd8, 16'h1010));
        prog.push_back(iType(6'd15, 5'd0, 5'd9, 16'hCAFE));
        prog.push_back(iType(6'd13, 5'd9, 5'd9, 16'hBABE));
        // Offset -8 from 0x1010
        prog.push_back(iType(6'd43, 5'd8, 5'd9, 16'hFFF8));
        prog.push_back(iType(6'd35, 5'd8, 5'd2, 16'hFFF8));
        endProgram();
        runProgram(1'b0);
        compareWord("memory", 32'hCAFEBABE, registerV0);
        compareWord("memory word", 32'hBEBAFECA, memRead(32'h00001008));
    endtask

    task automatic branchTest();
        logic [25:0] jumpField;
        jumpField = 26'((BOOT_ADDRESS + 32'd64) >> 2);
        prog = {};
        prog.push_back(iType(6'd9, 5'd0, 5'd8, 16'd5));
        prog.push_back(iType(6'd9, 5'd0, 5'd9, 16'd5));
        prog.push_back(iType(6'd4, 5'd8, 5'd9, 16'd2));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'd1));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'h100));
        prog.push_back(iType(6'd5, 5'd8, 5'd9, 16'd2));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'd2));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'd4));
        prog.push_back(iType(6'd5, 5'd8, 5'd0, 16'd2));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'd8));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'h200));
        prog.push_back(iType(6'd4, 5'd8, 5'd0, 16'd1));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'd16));
        prog.push_back({6'd2, jumpField});
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'd32));
        prog.push_back(iType(6'd9, 5'd2, 5'd2, 16'h400));
        endProgram();
        runProgram(1'b0);
        // Only the delay slots and fall-through adds count
        compareWord("branches", 32'd63, registerV0);
    endtask

    task automatic zeroRegHaltTest();
        prog = {};
        prog.push_back(iType(6'd9, 5'd0, 5'd0, 16'd55));
        prog.push_back(iType(6'd15, 5'd0, 5'd0, 16'hFFFF));
        prog.push_back(iType(6'd9, 5'd0, 5'd2, 16'd7));
        prog.push_back(rType(5'd2, 5'd0, 5'd2, 5'd0, 6'd37));
        endProgram();
        runProgram(1'b0);
        compareWord("register zero", 32'd7, registerV0);
        repeat (5) @(negedge clk);
        if (read || write || active) begin
            $display("halt: core left the halt state without reset");
            errorCount++;
        end
    endtask

    initial begin
        seed = 69;
        errorCount = 0;
        cycleCount = 0;
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        randomWaits = 1'b0;
        busy = 1'b0;
        waitLeft = 0;
        aluTest("alu", 1'b0);
        immediateShiftTest();
        memoryTest();
        branchTest();
        zeroRegHaltTest();
        aluTest("back-pressure", 1'b1);
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/mipsPkg.sv
src/alu.sv
src/regFile.sv
src/pcUnit.sv
src/controlFsm.sv
src/mipsCpuBus.sv
tests/tbClock.sv
tests/mipsCpuBus_assert.sv
tests/mipsTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mipsTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
